//--- hdl/aud_pkg.sv
`default_nettype none

package aud_pkg;

	// external sram geometry and sample size
	localparam int SRAM_AW  = 20;
	localparam int SAMPLE_W = 16;

	// speed word: bit 3 set means slow, bits 2:0 hold factor minus one
	localparam int SPEED_W      = 4;
	localparam int SPD_SLOW_BIT = 3;
	localparam int SPD_FACT_MSB = 2;
	localparam int SPD_FACT_LSB = 0;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RECD,
		ST_RECD_PAUSE,
		ST_PLAY,
		ST_PLAY_PAUSE
	} ctrl_state_e;

	// one-cycle strobes from the controller
	typedef struct packed {
		logic start;
		logic pause;
		logic stop;
	} rec_cmd_t;

	typedef struct packed {
		logic start;
		logic pause;
		logic stop;
	} play_cmd_t;

	// write request from the capture side
	typedef struct packed {
		logic [SRAM_AW-1:0]  addr;
		logic [SAMPLE_W-1:0] wdata;
		logic                we;
	} sram_req_t;

endpackage

`default_nettype wire

//--- hdl/rec_play_ctrl.sv
`default_nettype none

module rec_play_ctrl
	import aud_pkg::*;
(
	input  wire         i_AUD_BCLK,
	input  wire         i_rst_n,
	input  wire         i_key_rec,
	input  wire         i_key_play,
	input  wire         i_key_stop,
	input  wire         i_rec_fin,
	input  wire         i_play_fin,
	output rec_cmd_t    o_rec_cmd,
	output play_cmd_t   o_play_cmd,
	output logic        o_play_en,
	output ctrl_state_e o_state
);

	ctrl_state_e state_nxt;
	rec_cmd_t    rec_nxt;
	play_cmd_t   play_nxt;

	always_comb begin
		state_nxt = o_state;
		rec_nxt   = '0;
		play_nxt  = '0;
		case (o_state)
			ST_IDLE: begin
				// record wins if both keys arrive together
				if (i_key_rec) begin
					state_nxt     = ST_RECD;
					rec_nxt.start = 1'b1;
				end else if (i_key_play) begin
					state_nxt      = ST_PLAY;
					play_nxt.start = 1'b1;
				end
			end
			ST_RECD: begin
				if (i_key_stop || i_rec_fin) begin
					state_nxt    = ST_IDLE;
					rec_nxt.stop = 1'b1;
				end else if (i_key_rec) begin
					state_nxt     = ST_RECD_PAUSE;
					rec_nxt.pause = 1'b1;
				end
			end
			ST_RECD_PAUSE: begin
				if (i_key_stop) begin
					state_nxt    = ST_IDLE;
					rec_nxt.stop = 1'b1;
				end else if (i_key_rec) begin
					state_nxt     = ST_RECD;
					rec_nxt.start = 1'b1;
				end
			end
			ST_PLAY: begin
				if (i_key_stop || i_play_fin) begin
					state_nxt     = ST_IDLE;
					play_nxt.stop = 1'b1;
				end else if (i_key_play) begin
					state_nxt      = ST_PLAY_PAUSE;
					play_nxt.pause = 1'b1;
				end
			end
			ST_PLAY_PAUSE: begin
				if (i_key_stop) begin
					state_nxt     = ST_IDLE;
					play_nxt.stop = 1'b1;
				end else if (i_key_play) begin
					state_nxt      = ST_PLAY;
					play_nxt.start = 1'b1;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_AUD_BCLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_state    <= ST_IDLE;
			o_rec_cmd  <= '0;
			o_play_cmd <= '0;
			o_play_en  <= 1'b0;
		end else begin
			o_state    <= state_nxt;
			o_rec_cmd  <= rec_nxt;
			o_play_cmd <= play_nxt;
			o_play_en  <= (state_nxt == ST_PLAY);
		end
	end

	a_rec_cmd_onehot: assert property (@(posedge i_AUD_BCLK) disable iff (!i_rst_n)
		$onehot0(o_rec_cmd));
	a_play_cmd_onehot: assert property (@(posedge i_AUD_BCLK) disable iff (!i_rst_n)
		$onehot0(o_play_cmd));

endmodule

`default_nettype wire

//--- hdl/i2s_capture.sv
`default_nettype none

module i2s_capture
	import aud_pkg::*;
#(
	parameter int P_ADDR_W = 20
) (
	input  wire                i_AUD_BCLK,
	input  wire                i_rst_n,
	input  rec_cmd_t           i_rec_cmd,
	input  wire                i_adclrck,
	input  wire                i_adcdat,
	output sram_req_t          o_req,
	output logic [SRAM_AW-1:0] o_rec_len,
	output logic               o_rec_fin
);

	logic                running;
	logic                paused;
	logic                busy;
	logic                lrck_q;
	logic                we;
	logic [4:0]          bit_cnt;
	logic [P_ADDR_W-1:0] addr;
	logic [SAMPLE_W-1:0] shift;

	assign o_req = '{addr: SRAM_AW'(addr), wdata: shift, we: we};

	// adc sample shift register, filled msb first
	always_ff @(posedge i_AUD_BCLK) begin
		if (busy && bit_cnt >= 5'd1 && bit_cnt <= 5'd16) begin
			shift <= {shift[SAMPLE_W-2:0], i_adcdat};
		end
	end

	always_ff @(posedge i_AUD_BCLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			running   <= 1'b0;
			paused    <= 1'b0;
			busy      <= 1'b0;
			lrck_q    <= 1'b0;
			we        <= 1'b0;
			bit_cnt   <= '0;
			addr      <= '0;
			o_rec_len <= '0;
			o_rec_fin <= 1'b0;
		end else begin
			lrck_q    <= i_adclrck;
			we        <= 1'b0;
			o_rec_fin <= 1'b0;
			// finish the write cycle: advance, or stop at the top of memory
			if (we) begin
				o_rec_len <= SRAM_AW'(addr) + SRAM_AW'(1);
				if (&addr) begin
					o_rec_fin <= 1'b1;
					running   <= 1'b0;
				end else begin
					addr <= addr + 1'b1;
				end
			end
			if (i_rec_cmd.start) begin
				running <= 1'b1;
				paused  <= 1'b0;
				if (!paused) begin
					addr      <= '0;
					o_rec_len <= '0;
				end
			end else if (i_rec_cmd.pause || i_rec_cmd.stop) begin
				running <= 1'b0;
				paused  <= i_rec_cmd.pause;
				busy    <= 1'b0;
			end else if (busy) begin
				bit_cnt <= bit_cnt + 1'b1;
				// slot 0 is the i2s delay bit, 1..16 carry data
				if (bit_cnt == 5'd17) begin
					busy <= 1'b0;
					we   <= 1'b1;
				end
			end else if (running && lrck_q && !i_adclrck) begin
				busy    <= 1'b1;
				bit_cnt <= '0;
			end
		end
	end

	a_we_single: assert property (@(posedge i_AUD_BCLK) disable iff (!i_rst_n)
		o_req.we |=> !o_req.we);

endmodule

`default_nettype wire

//--- hdl/play_addr_gen.sv
`default_nettype none

module play_addr_gen
	import aud_pkg::*;
#(
	parameter int P_ADDR_W = 20
) (
	input  wire                 i_AUD_BCLK,
	input  wire                 i_rst_n,
	input  play_cmd_t           i_play_cmd,
	input  wire  [SPEED_W-1:0]  i_speed,
	input  wire                 i_daclrck,
	input  wire  [SAMPLE_W-1:0] i_sram_rdata,
	input  wire  [SRAM_AW-1:0]  i_rec_len,
	output logic [SRAM_AW-1:0]  o_rd_addr,
	output logic [SAMPLE_W-1:0] o_sample,
	output logic                o_play_fin,
	output logic                o_frame_load
);

	localparam int FACT_W = SPD_FACT_MSB - SPD_FACT_LSB + 1;

	logic                playing;
	logic                paused;
	logic                fetch;
	logic                done;
	logic                lrck_q;
	logic                slow;
	logic [FACT_W-1:0]   fact_m1;
	logic [FACT_W-1:0]   hold_cnt;
	logic [P_ADDR_W-1:0] addr;
	logic [SRAM_AW:0]    step;
	logic [SRAM_AW:0]    addr_nxt;

	assign slow      = i_speed[SPD_SLOW_BIT];
	assign fact_m1   = i_speed[SPD_FACT_MSB:SPD_FACT_LSB];
	assign o_rd_addr = SRAM_AW'(addr);

	// slow mode steps by one once the hold count is used up
	assign step     = slow ? (SRAM_AW + 1)'(1) : (SRAM_AW + 1)'(fact_m1) + 1'b1;
	assign addr_nxt = {1'b0, o_rd_addr} + step;

	always_ff @(posedge i_AUD_BCLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			playing      <= 1'b0;
			paused       <= 1'b0;
			fetch        <= 1'b0;
			done         <= 1'b0;
			lrck_q       <= 1'b0;
			hold_cnt     <= '0;
			addr         <= '0;
			o_play_fin   <= 1'b0;
			o_frame_load <= 1'b0;
		end else begin
			lrck_q       <= i_daclrck;
			o_play_fin   <= 1'b0;
			o_frame_load <= 1'b0;
			if (i_play_cmd.start) begin
				paused <= 1'b0;
				if (!paused) begin
					addr     <= '0;
					hold_cnt <= '0;
					done     <= 1'b0;
				end
				// nothing recorded, end right away
				if (i_rec_len == '0) begin
					o_play_fin <= 1'b1;
				end else begin
					playing <= 1'b1;
				end
			end else if (i_play_cmd.pause || i_play_cmd.stop) begin
				playing <= 1'b0;
				paused  <= i_play_cmd.pause;
				fetch   <= 1'b0;
			end else if (fetch) begin
				fetch        <= 1'b0;
				o_sample     <= i_sram_rdata;
				o_frame_load <= 1'b1;
				if (slow && hold_cnt != fact_m1) begin
					hold_cnt <= hold_cnt + 1'b1;
				end else if (addr_nxt >= {1'b0, i_rec_len}) begin
					done <= 1'b1;
				end else begin
					hold_cnt <= '0;
					addr     <= P_ADDR_W'(addr_nxt);
				end
			end else if (playing && lrck_q && !i_daclrck) begin
				// last sample already sent, finish instead of fetching again
				if (done) begin
					playing    <= 1'b0;
					o_play_fin <= 1'b1;
				end else begin
					fetch <= 1'b1;
				end
			end
		end
	end

	a_addr_in_range: assert property (@(posedge i_AUD_BCLK) disable iff (!i_rst_n)
		playing |-> o_rd_addr < i_rec_len);

endmodule

`default_nettype wire

//--- hdl/i2s_serializer.sv
`default_nettype none

module i2s_serializer
	import aud_pkg::*;
(
	input  wire                i_AUD_BCLK,
	input  wire                i_rst_n,
	input  wire                i_en,
	input  wire                i_load,
	input  wire [SAMPLE_W-1:0] i_sample,
	output logic               o_dacdat
);

	logic [SAMPLE_W-1:0] shift;
	logic [4:0]          bits_left;

	// msb first, silent once the word is out or playback is off
	assign o_dacdat = (i_en && bits_left != '0) ? shift[SAMPLE_W-1] : 1'b0;

	always_ff @(posedge i_AUD_BCLK) begin
		if (i_en && i_load) begin
			shift <= i_sample;
		end else begin
			shift <= {shift[SAMPLE_W-2:0], 1'b0};
		end
	end

	always_ff @(posedge i_AUD_BCLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bits_left <= '0;
		end else if (!i_en) begin
			bits_left <= '0;
		end else if (i_load) begin
			bits_left <= 5'(SAMPLE_W);
		end else if (bits_left != '0) begin
			bits_left <= bits_left - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/aud_top.sv
`default_nettype none

module aud_top
	import aud_pkg::*;
#(
	parameter int P_ADDR_W = 20
) (
	input  wire                 i_AUD_BCLK,
	input  wire                 i_rst_n,
	input  wire                 i_key_rec,
	input  wire                 i_key_play,
	input  wire                 i_key_stop,
	input  wire  [SPEED_W-1:0]  i_speed,
	input  wire                 i_AUD_ADCLRCK,
	input  wire                 i_AUD_ADCDAT,
	input  wire                 i_AUD_DACLRCK,
	output logic                o_AUD_DACDAT,
	output logic [SRAM_AW-1:0]  o_sram_addr,
	inout  wire  [SAMPLE_W-1:0] io_sram_dq,
	output logic                o_sram_we_n,
	output ctrl_state_e         o_state
);

	rec_cmd_t            rec_cmd;
	play_cmd_t           play_cmd;
	sram_req_t           req;
	logic                play_en;
	logic                rec_fin;
	logic                play_fin;
	logic                frame_load;
	logic [SRAM_AW-1:0]  rec_len;
	logic [SRAM_AW-1:0]  rd_addr;
	logic [SAMPLE_W-1:0] sample;

	// a write still in flight keeps the bus even if the state just moved on
	assign o_sram_addr = (o_state == ST_RECD || req.we) ? req.addr : rd_addr;
	assign io_sram_dq  = req.we ? req.wdata : {SAMPLE_W{1'bz}};
	assign o_sram_we_n = ~req.we;

	rec_play_ctrl u_ctrl (
		.i_AUD_BCLK (i_AUD_BCLK),
		.i_rst_n    (i_rst_n),
		.i_key_rec  (i_key_rec),
		.i_key_play (i_key_play),
		.i_key_stop (i_key_stop),
		.i_rec_fin  (rec_fin),
		.i_play_fin (play_fin),
		.o_rec_cmd  (rec_cmd),
		.o_play_cmd (play_cmd),
		.o_play_en  (play_en),
		.o_state    (o_state)
	);

	i2s_capture #(.P_ADDR_W(P_ADDR_W)) u_capture (
		.i_AUD_BCLK (i_AUD_BCLK),
		.i_rst_n    (i_rst_n),
		.i_rec_cmd  (rec_cmd),
		.i_adclrck  (i_AUD_ADCLRCK),
		.i_adcdat   (i_AUD_ADCDAT),
		.o_req      (req),
		.o_rec_len  (rec_len),
		.o_rec_fin  (rec_fin)
	);

	play_addr_gen #(.P_ADDR_W(P_ADDR_W)) u_addr_gen (
		.i_AUD_BCLK   (i_AUD_BCLK),
		.i_rst_n      (i_rst_n),
		.i_play_cmd   (play_cmd),
		.i_speed      (i_speed),
		.i_daclrck    (i_AUD_DACLRCK),
		.i_sram_rdata (io_sram_dq),
		.i_rec_len    (rec_len),
		.o_rd_addr    (rd_addr),
		.o_sample     (sample),
		.o_play_fin   (play_fin),
		.o_frame_load (frame_load)
	);

	i2s_serializer u_serializer (
		.i_AUD_BCLK (i_AUD_BCLK),
		.i_rst_n    (i_rst_n),
		.i_en       (play_en),
		.i_load     (frame_load),
		.i_sample   (sample),
		.o_dacdat   (o_AUD_DACDAT)
	);

endmodule

`default_nettype wire

//--- test/tb_codec_sram.sv
`default_nettype none

module tb_codec_sram #(
	parameter int P_DEPTH = 64
) (
	input  wire         i_clk,
	input  wire  [19:0] i_sram_addr,
	inout  wire  [15:0] io_sram_dq,
	input  wire         i_sram_we_n,
	output logic        o_lrck,
	output logic        o_adcdat,
	output logic [4:0]  o_slot
);

	logic [15:0] mem [0:P_DEPTH-1];
	// every sample put on the adc line, one per frame
	logic [15:0] sent [0:511];
	int          n_sent = 0;
	integer      seed = 96926;
	logic [4:0]  slot = 5'd31;
	logic        lrck = 1'b1;
	logic        dat = 1'b0;
	logic [15:0] cur = '0;
	logic [4:0]  nxt;
	logic [31:0] rnd;

	assign o_slot   = slot;
	assign o_lrck   = lrck;
	assign o_adcdat = dat;

	// read data comes back without a clock
	assign io_sram_dq = i_sram_we_n ? mem[i_sram_addr] : 16'bz;

	initial begin
		for (int i = 0; i < P_DEPTH; i++) begin
			mem[i] = 16'hc3a0 ^ 16'(i);
		end
	end

	// write lands at the bclk edge that closes the write strobe
	always @(posedge i_clk) begin
		if (!i_sram_we_n) begin
			mem[i_sram_addr] <= io_sram_dq;
		end
	end

	// 32 slots per frame, left channel while lrck is low
	// the dut sees the frame edge at slot 0 and takes the msb at slot 2
	always @(posedge i_clk) begin
		nxt = slot + 1'b1;
		if (nxt == 5'd0) begin
			rnd = $random(seed);
			sent[n_sent] <= rnd[15:0];
			n_sent       <= n_sent + 1;
			cur          <= rnd[15:0];
		end
		slot <= nxt;
		lrck <= nxt[4];
		dat  <= (nxt >= 5'd2 && nxt <= 5'd17) ? cur[17 - nxt] : 1'b0;
	end

endmodule

`default_nettype wire

//--- test/tb_aud_top.sv
`default_nettype none

module tb_aud_top
	import aud_pkg::*;
();

	localparam int ADDR_W   = 6;
	localparam int DEPTH    = 64;
	localparam int KEY_REC  = 0;
	localparam int KEY_PLAY = 1;
	localparam int KEY_STOP = 2;
	// frames per test: reset, record, normal, fast and slow, pause, full memory
	localparam int TEST_FRAMES = 2 + 24 + 24 + 56 + 50 + 136;
	localparam int CYCLE_LIMIT = TEST_FRAMES * 32 * 3 / 2;

	logic                clk;
	logic                rst_n;
	logic                key_rec;
	logic                key_play;
	logic                key_stop;
	logic [SPEED_W-1:0]  speed;
	wire                 lrck;
	wire                 adcdat;
	wire                 dacdat;
	wire                 we_n;
	wire  [SRAM_AW-1:0]  sram_addr;
	wire  [SAMPLE_W-1:0] sram_dq;
	wire  [4:0]          slot;
	ctrl_state_e         state;

	logic [SAMPLE_W-1:0] rec_q [0:DEPTH-1];
	logic [SAMPLE_W-1:0] dac_word;
	logic [SAMPLE_W-1:0] exp_smp;
	int                  rec_n;
	int                  play_k;
	int                  errors;
	int                  checks;
	int                  err_mark;
	int                  test_no;
	int                  first;
	int                  cycles;

	aud_top #(.P_ADDR_W(ADDR_W)) u_dut (
		.i_AUD_BCLK    (clk),
		.i_rst_n       (rst_n),
		.i_key_rec     (key_rec),
		.i_key_play    (key_play),
		.i_key_stop    (key_stop),
		.i_speed       (speed),
		.i_AUD_ADCLRCK (lrck),
		.i_AUD_ADCDAT  (adcdat),
		.i_AUD_DACLRCK (lrck),
		.o_AUD_DACDAT  (dacdat),
		.o_sram_addr   (sram_addr),
		.io_sram_dq    (sram_dq),
		.o_sram_we_n   (we_n),
		.o_state       (state)
	);

	tb_codec_sram #(.P_DEPTH(DEPTH)) u_codec (
		.i_clk       (clk),
		.i_sram_addr (sram_addr),
		.io_sram_dq  (sram_dq),
		.i_sram_we_n (we_n),
		.o_lrck      (lrck),
		.o_adcdat    (adcdat),
		.o_slot      (slot)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// expected dac sample for output frame k, zero return once playback is over
	function automatic bit exp_play_seq(input logic [SPEED_W-1:0] spd, input int k,
		output logic [SAMPLE_W-1:0] smp);
		int fact;
		int addr;
		// bit 3 slow, bits 2:0 factor minus one
		fact = int'(spd[2:0]) + 1;
		addr = spd[3] ? k / fact : k * fact;
		smp  = '0;
		if (addr >= rec_n) begin
			return 1'b0;
		end
		smp = rec_q[addr];
		return 1'b1;
	endfunction

	task automatic check_val(input string name, input logic [SAMPLE_W-1:0] exp,
		input logic [SAMPLE_W-1:0] act);
		checks++;
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	// each frame passes slot 20 once, after its sample is written
	task automatic wait_frames(input int n);
		repeat (n) begin
			do begin
				@(posedge clk);
			end while (slot != 5'd20);
		end
	endtask

	task automatic press_key(input int key);
		wait_frames(1);
		key_rec  <= (key == KEY_REC);
		key_play <= (key == KEY_PLAY);
		key_stop <= (key == KEY_STOP);
		@(posedge clk);
		key_rec  <= 1'b0;
		key_play <= 1'b0;
		key_stop <= 1'b0;
	endtask

	task automatic wait_idle();
		do begin
			@(posedge clk);
		end while (state != ST_IDLE);
	endtask

	task automatic grab_recording(input int from, input int to);
		for (int i = from; i < to && rec_n < DEPTH; i++) begin
			rec_q[rec_n] = u_codec.sent[i];
			rec_n++;
		end
	endtask

	task automatic check_sram();
		for (int i = 0; i < rec_n; i++) begin
			check_val($sformatf("sram[%0d]", i), rec_q[i], u_codec.mem[i]);
		end
	endtask

	task automatic run_playback(input logic [SPEED_W-1:0] spd, input int pause_after);
		int                  n_exp;
		logic [SAMPLE_W-1:0] smp_tmp;
		n_exp = 0;
		while (exp_play_seq(spd, n_exp, smp_tmp)) begin
			n_exp++;
		end
		@(posedge clk);
		speed  <= spd;
		play_k = 0;
		press_key(KEY_PLAY);
		if (pause_after > 0) begin
			wait_frames(pause_after);
			press_key(KEY_PLAY);
			wait_frames(3);
			check_val("o_state", ST_PLAY_PAUSE, state);
			press_key(KEY_PLAY);
		end
		wait_idle();
		if (play_k != n_exp) begin
			$display("Playback at speed %h gave %0d frames, expected %0d", spd, play_k, n_exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %s", test_no, name, (errors == err_mark) ? "ok" : "FAILED");
		test_no++;
		err_mark = errors;
	endtask

	// dac word built from slots 3..18, judged once per frame
	always @(negedge clk) begin
		if (rst_n && slot >= 5'd3 && slot <= 5'd18) begin
			dac_word = {dac_word[SAMPLE_W-2:0], dacdat};
			if (slot == 5'd18) begin
				if (state != ST_PLAY) begin
					check_val("o_AUD_DACDAT", '0, dac_word);
				end else if (exp_play_seq(speed, play_k, exp_smp)) begin
					check_val("o_AUD_DACDAT", exp_smp, dac_word);
					play_k++;
				end else begin
					$display("Playback ran past the recorded length at frame %0d", play_k);
					errors++;
					play_k++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d clock cycles without finishing", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		rst_n    = 1'b0;
		key_rec  = 1'b0;
		key_play = 1'b0;
		key_stop = 1'b0;
		speed    = '0;
		dac_word = '0;
		rec_n    = 0;
		play_k   = 0;
		errors   = 0;
		checks   = 0;
		err_mark = 0;
		test_no  = 1;
		cycles   = 0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_val("o_state", ST_IDLE, state);
		check_val("o_sram_we_n", 1'b1, we_n);
		check_val("o_AUD_DACDAT", 1'b0, dacdat);
		end_test("reset");

		press_key(KEY_REC);
		first = u_codec.n_sent;
		wait_frames(19);
		press_key(KEY_STOP);
		grab_recording(first, u_codec.n_sent);
		@(negedge clk);
		check_val("o_state", ST_IDLE, state);
		check_sram();
		end_test("record 20 frames");

		run_playback(4'b0000, 0);
		end_test("play normal speed");

		// fast x3, then slow x2
		run_playback(4'b0010, 0);
		run_playback(4'b1001, 0);
		end_test("play fast and slow");

		rec_n = 0;
		press_key(KEY_REC);
		first = u_codec.n_sent;
		wait_frames(5);
		press_key(KEY_REC);
		grab_recording(first, u_codec.n_sent);
		wait_frames(2);
		press_key(KEY_REC);
		first = u_codec.n_sent;
		wait_frames(5);
		press_key(KEY_STOP);
		grab_recording(first, u_codec.n_sent);
		check_sram();
		// pause lands mid-hold in slow mode
		run_playback(4'b1001, 4);
		end_test("record and play pause");

		rec_n = 0;
		press_key(KEY_REC);
		first = u_codec.n_sent;
		wait_idle();
		grab_recording(first, first + DEPTH);
		check_sram();
		run_playback(4'b0000, 0);
		end_test("fill memory");

		$display("%0d tests, %0d checks, %0d errors", test_no - 1, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hdl/aud_pkg.sv
hdl/rec_play_ctrl.sv
hdl/i2s_capture.sv
hdl/play_addr_gen.sv
hdl/i2s_serializer.sv
hdl/aud_top.sv
test/tb_codec_sram.sv
test/tb_aud_top.sv
